/* hw/fetch_pc_tracker.sv */
// fetch program counter tracker

`timescale 1ns/1ps
`default_nettype none

`include "instr_prefetch_cfg.svh"

module fetch_pc_tracker (
  input  wire                            clk,
  input  wire                            rst_n,
  input  logic                           branch_i,
  input  instr_prefetch_pkg::addr_t      addr_i,
  input  logic                           ready_i,
  input  logic                           valid_i,
  input  instr_prefetch_pkg::instr_t     instr_i,
  output instr_prefetch_pkg::fetch_out_t fetch_o
);

  // pc of the instruction currently offered to decode
  instr_prefetch_pkg::addr_t pc_q;
  logic                      transfer;

  assign transfer = valid_i & ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // pc register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (branch_i) begin
      // redirect, target forced onto a word boundary
      pc_q <= {addr_i[`PF_ADDR_WIDTH-1:2], 2'b00};
    end else if (transfer) begin
      // one word consumed by decode
      pc_q <= pc_q + `PF_ADDR_WIDTH'd4;
    end
  end

  // bundle for decode
  assign fetch_o.valid = valid_i;
  assign fetch_o.instr = instr_i;
  assign fetch_o.pc    = pc_q;

endmodule

`default_nettype wire

/* hw/instr_fifo.sv */
// instruction buffer

`timescale 1ns/1ps
`default_nettype none

`include "instr_prefetch_cfg.svh"

module instr_fifo #(
  parameter int DEPTH       = `PF_FIFO_DEPTH,
  parameter int ALM_FULL_TH = `PF_ALM_FULL_TH
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  logic                       flush_i,
  input  logic                       push_i,
  input  instr_prefetch_pkg::instr_t data_i,
  input  logic                       pop_i,
  output instr_prefetch_pkg::instr_t data_o,
  output logic                       full_o,
  output logic                       alm_full_o,
  output logic                       empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push_en, pop_en;

  // storage array, payload only
  instr_prefetch_pkg::instr_t mem_q [DEPTH];

  // a pop frees a slot in the same cycle, so a full buffer still takes a push
  assign pop_en  = pop_i & ~empty_o;
  assign push_en = push_i & (~full_o | pop_en);

  assign empty_o    = (count_q == '0);
  assign full_o     = (count_q == CNT_W'(DEPTH));
  assign alm_full_o = (count_q >= CNT_W'(ALM_FULL_TH));

  // head of the buffer, registered storage so no fall-through
  assign data_o = mem_q[rd_ptr_q];

  ////////////////////////////////////////////////////////////////////////////
  // pointers and fill count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // flush wins over any push in the same cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        if (wr_ptr_q == PTR_W'(DEPTH - 1)) wr_ptr_q <= '0;
        else wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        if (rd_ptr_q == PTR_W'(DEPTH - 1)) rd_ptr_q <= '0;
        else rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // count only moves when exactly one side is active
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // write port
  always_ff @(posedge clk) begin
    if (push_en && !flush_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* hw/instr_prefetch_cfg.svh */
// instruction prefetch configuration

`ifndef INSTR_PREFETCH_CFG_SVH
`define INSTR_PREFETCH_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////////////////////

// byte address and instruction word width
`define PF_ADDR_WIDTH 32

////////////////////////////////////////////////////////////////////////////
// instruction buffer sizing
////////////////////////////////////////////////////////////////////////////

// number of buffered instruction words
`define PF_FIFO_DEPTH 2
// fill level that stops new requests
`define PF_ALM_FULL_TH 1

`endif

/* hw/instr_prefetch_pkg.sv */
// instruction prefetch types

`default_nettype none

`include "instr_prefetch_cfg.svh"

package instr_prefetch_pkg;

  // byte address into instruction memory
  typedef logic [`PF_ADDR_WIDTH-1:0] addr_t;
  // raw 32 bit instruction word
  typedef logic [`PF_ADDR_WIDTH-1:0] instr_t;

  // fetch fsm states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED,
    WAIT_JUMP
  } fetch_state_e;

  // request towards instruction memory
  typedef struct packed {
    logic  req;
    addr_t addr;
  } imem_req_t;

  // response from instruction memory
  typedef struct packed {
    logic   gnt;
    logic   rvalid;
    logic   err_pmp;
    instr_t rdata;
  } imem_rsp_t;

  // instruction handed to decode
  typedef struct packed {
    logic   valid;
    instr_t instr;
    addr_t  pc;
  } fetch_out_t;

endpackage

`default_nettype wire

/* hw/instr_prefetch_top.sv */
// instruction prefetch top level

`timescale 1ns/1ps
`default_nettype none

module instr_prefetch_top (
  input  wire                            clk,
  input  wire                            rst_n,
  input  logic                           req_i,
  input  logic                           branch_i,
  input  instr_prefetch_pkg::addr_t      addr_i,
  input  logic                           ready_i,
  output instr_prefetch_pkg::imem_req_t  imem_req_o,
  input  instr_prefetch_pkg::imem_rsp_t  imem_rsp_i,
  output instr_prefetch_pkg::fetch_out_t fetch_o,
  output logic                           fetch_failed_o,
  output logic                           busy_o
);

  // fetch data between buffer and pc tracker
  logic                       fetch_valid;
  instr_prefetch_pkg::instr_t fetch_instr;

  prefetch_buffer prefetch_buffer_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .addr_i         (addr_i),
    .ready_i        (ready_i),
    .imem_req_o     (imem_req_o),
    .imem_rsp_i     (imem_rsp_i),
    .valid_o        (fetch_valid),
    .instr_o        (fetch_instr),
    .fetch_failed_o (fetch_failed_o),
    .busy_o         (busy_o)
  );

  // adds the pc to each instruction
  fetch_pc_tracker pc_tracker_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .branch_i (branch_i),
    .addr_i   (addr_i),
    .ready_i  (ready_i),
    .valid_i  (fetch_valid),
    .instr_i  (fetch_instr),
    .fetch_o  (fetch_o)
  );

endmodule

`default_nettype wire

/* hw/prefetch_buffer.sv */
// prefetch buffer and fetch fsm

`timescale 1ns/1ps
`default_nettype none

`include "instr_prefetch_cfg.svh"

module prefetch_buffer (
  input  wire                           clk,
  input  wire                           rst_n,
  input  logic                          req_i,
  input  logic                          branch_i,
  input  instr_prefetch_pkg::addr_t     addr_i,
  input  logic                          ready_i,
  output instr_prefetch_pkg::imem_req_t imem_req_o,
  input  instr_prefetch_pkg::imem_rsp_t imem_rsp_i,
  output logic                          valid_o,
  output instr_prefetch_pkg::instr_t    instr_o,
  output logic                          fetch_failed_o,
  output logic                          busy_o
);

  instr_prefetch_pkg::fetch_state_e state_q, state_d;

  // last issued address and the next sequential word after it
  instr_prefetch_pkg::addr_t instr_addr_q, fetch_addr;
  instr_prefetch_pkg::addr_t instr_addr;
  logic                      instr_req;
  logic                      addr_valid;

  // buffer control
  logic                       fifo_push, fifo_pop;
  logic                       fifo_full, fifo_alm_full, fifo_empty;
  logic                       fifo_valid, fifo_ready;
  instr_prefetch_pkg::instr_t fifo_rdata;

  assign imem_req_o.req  = instr_req;
  assign imem_req_o.addr = instr_addr;

  assign busy_o = (state_q != instr_prefetch_pkg::IDLE) || instr_req;

  // word aligned increment
  assign fetch_addr = {instr_addr_q[`PF_ADDR_WIDTH-1:2], 2'b00} + `PF_ADDR_WIDTH'd4;

  ////////////////////////////////////////////////////////////////////////////
  // fetch fsm
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    instr_req      = 1'b0;
    instr_addr     = fetch_addr;
    addr_valid     = 1'b0;
    fifo_push      = 1'b0;
    fetch_failed_o = 1'b0;

    case (state_q)
      // nothing outstanding
      instr_prefetch_pkg::IDLE: begin
        if (branch_i) instr_addr = addr_i;
        // branch target always goes out, sequential only with buffer room
        if (req_i && (fifo_ready || branch_i)) begin
          instr_req  = 1'b1;
          addr_valid = 1'b1;
          if (imem_rsp_i.gnt && imem_rsp_i.err_pmp) state_d = instr_prefetch_pkg::WAIT_JUMP;
          else if (imem_rsp_i.gnt) state_d = instr_prefetch_pkg::WAIT_RVALID;
          else state_d = instr_prefetch_pkg::WAIT_GNT;
        end
      end

      // request raised, hold it until granted
      instr_prefetch_pkg::WAIT_GNT: begin
        instr_req  = 1'b1;
        instr_addr = instr_addr_q;
        // a branch replaces the pending address
        if (branch_i) begin
          instr_addr = addr_i;
          addr_valid = 1'b1;
        end
        if (imem_rsp_i.gnt && imem_rsp_i.err_pmp) state_d = instr_prefetch_pkg::WAIT_JUMP;
        else if (imem_rsp_i.gnt) state_d = instr_prefetch_pkg::WAIT_RVALID;
      end

      // granted, waiting for the data
      instr_prefetch_pkg::WAIT_RVALID: begin
        if (branch_i) instr_addr = addr_i;
        if (req_i && (fifo_ready || branch_i)) begin
          if (imem_rsp_i.rvalid) begin
            // data back, chain the next request in the same cycle
            instr_req  = 1'b1;
            addr_valid = 1'b1;
            fifo_push  = fifo_valid | ~ready_i;
            if (imem_rsp_i.gnt && imem_rsp_i.err_pmp) state_d = instr_prefetch_pkg::WAIT_JUMP;
            else if (imem_rsp_i.gnt) state_d = instr_prefetch_pkg::WAIT_RVALID;
            else state_d = instr_prefetch_pkg::WAIT_GNT;
          end else if (branch_i) begin
            // old data still on its way, drop it when it lands
            addr_valid = 1'b1;
            state_d    = instr_prefetch_pkg::WAIT_ABORTED;
          end
        end else if (imem_rsp_i.rvalid) begin
          // no further request wanted or no room
          fifo_push = fifo_valid | ~ready_i;
          state_d   = instr_prefetch_pkg::IDLE;
        end else if (branch_i) begin
          addr_valid = 1'b1;
          state_d    = instr_prefetch_pkg::WAIT_ABORTED;
        end
      end

      // stale response pending, target held in instr_addr_q
      instr_prefetch_pkg::WAIT_ABORTED: begin
        instr_addr = instr_addr_q;
        if (branch_i) begin
          instr_addr = addr_i;
          addr_valid = 1'b1;
        end
        if (imem_rsp_i.rvalid) begin
          if (req_i || branch_i) begin
            instr_req = 1'b1;
            if (imem_rsp_i.gnt && imem_rsp_i.err_pmp) state_d = instr_prefetch_pkg::WAIT_JUMP;
            else if (imem_rsp_i.gnt) state_d = instr_prefetch_pkg::WAIT_RVALID;
            else state_d = instr_prefetch_pkg::WAIT_GNT;
          end else begin
            state_d = instr_prefetch_pkg::IDLE;
          end
        end
      end

      // pmp fault seen, only a branch restarts fetching
      instr_prefetch_pkg::WAIT_JUMP: begin
        fetch_failed_o = ~valid_o;
        if (branch_i) begin
          instr_addr     = addr_i;
          instr_req      = 1'b1;
          addr_valid     = 1'b1;
          fetch_failed_o = 1'b0;
          if (imem_rsp_i.gnt && imem_rsp_i.err_pmp) state_d = instr_prefetch_pkg::WAIT_JUMP;
          else if (imem_rsp_i.gnt) state_d = instr_prefetch_pkg::WAIT_RVALID;
          else state_d = instr_prefetch_pkg::WAIT_GNT;
        end
      end

      default: state_d = instr_prefetch_pkg::IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and address registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= instr_prefetch_pkg::IDLE;
      instr_addr_q <= '0;
    end else begin
      state_q <= state_d;
      if (addr_valid) instr_addr_q <= instr_addr;
    end
  end

  // buffer is cleared in the branch cycle
  instr_fifo #(
    .DEPTH       (`PF_FIFO_DEPTH),
    .ALM_FULL_TH (`PF_ALM_FULL_TH)
  ) instr_buffer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (branch_i),
    .push_i     (fifo_push),
    .data_i     (imem_rsp_i.rdata),
    .pop_i      (fifo_pop),
    .data_o     (fifo_rdata),
    .full_o     (fifo_full),
    .alm_full_o (fifo_alm_full),
    .empty_o    (fifo_empty)
  );

  assign fifo_valid = ~fifo_empty;
  assign fifo_ready = ~(fifo_alm_full | fifo_full);

  ////////////////////////////////////////////////////////////////////////////
  // output selection
  ////////////////////////////////////////////////////////////////////////////

  // buffer head leads, the live response only passes when nothing is queued
  // a branch kills whatever sits at the decode interface this cycle
  always_comb begin
    fifo_pop = 1'b0;
    if (fifo_valid) begin
      instr_o  = fifo_rdata;
      valid_o  = ~branch_i;
      fifo_pop = ready_i;
    end else begin
      instr_o = imem_rsp_i.rdata & {`PF_ADDR_WIDTH{imem_rsp_i.rvalid}};
      valid_o = imem_rsp_i.rvalid & (state_q != instr_prefetch_pkg::WAIT_ABORTED) & ~branch_i;
    end
  end

endmodule

`default_nettype wire

/* instr_prefetch.f */
+incdir+hw
+incdir+verification
hw/instr_prefetch_pkg.sv
hw/instr_fifo.sv
hw/prefetch_buffer.sv
hw/fetch_pc_tracker.sv
hw/instr_prefetch_top.sv
verification/tb_clk_gen.sv
verification/tb_instr_prefetch.sv

/* verification/tb_clk_gen.sv */
// testbench clock source

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk_o
);

  // free running, starts low
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

/* verification/tb_instr_prefetch_tests.svh */
// directed prefetch tests

`ifndef TB_INSTR_PREFETCH_TESTS_SVH
`define TB_INSTR_PREFETCH_TESTS_SVH

  ////////////////////////////////////////////////////////////////////////////
  // helpers entered right after a rising edge
  ////////////////////////////////////////////////////////////////////////////

  // one cycle branch pulse that also clears the transfer log
  task automatic branch_to(input instr_prefetch_pkg::addr_t target);
    branch <= 1'b1;
    addr   <= target;
    @(posedge clk);
    branch <= 1'b0;
    got_instr.delete();
    got_pc.delete();
  endtask

  // wait for n transfers with optional random decode stalls
  task automatic collect(input int n, input bit stall);
    int cyc;
    cyc = 0;
    while (got_pc.size() < n && cyc < TIMEOUT_CYC) begin
      @(posedge clk);
      ready <= stall ? 1'($random(seed)) : 1'b1;
      cyc++;
    end
    if (got_pc.size() < n) begin
      $display("timeout waiting for %0d transfers to decode", n);
      timeouts++;
    end
    ready <= 1'b1;
  endtask

  // pc steps by four from base and each word is the inverted pc
  task automatic check_stream(input instr_prefetch_pkg::addr_t base, input int n);
    instr_prefetch_pkg::addr_t pc;
    int                        i;
    for (i = 0; i < n && i < got_pc.size(); i++) begin
      pc = base + 32'(4 * i);
      check_addr("fetch_o.pc", pc, got_pc[i]);
      check_instr("fetch_o.instr", ~pc, got_instr[i]);
    end
  endtask

  // nothing requested and nothing offered to decode
  task automatic check_quiet(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      check_flag("busy_o", 1'b0, busy);
      check_flag("imem_req_o.req", 1'b0, imem_req.req);
      check_flag("fetch_o.valid", 1'b0, fetch.valid);
      check_flag("fetch_failed_o", 1'b0, fetch_failed);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_idle_after_reset();
    check_quiet(10);
    // pc comes out of reset at zero
    check_addr("fetch_o.pc", 32'h0, fetch.pc);
  endtask

  task automatic test_sequential();
    req <= 1'b1;
    branch_to(32'h0000_0100);
    collect(16, 1'b0);
    check_stream(32'h0000_0100, 16);
  endtask

  // same stream under decode back-pressure
  task automatic test_backpressure();
    branch_to(32'h0000_2000);
    collect(16, 1'b1);
    check_stream(32'h0000_2000, 16);
  endtask

  task automatic test_branch_mid_stream();
    int   cyc;
    logic found;
    branch_to(32'h0000_3000);
    collect(4, 1'b0);
    found = 1'b0;
    cyc   = 0;
    // branch right after a grant while the data is still on its way
    while (!found && cyc < TIMEOUT_CYC) begin
      @(posedge clk);
      found = imem_req.req && imem_rsp.gnt;
      cyc++;
    end
    if (!found) begin
      $display("timeout waiting for a memory grant");
      timeouts++;
    end
    branch_to(32'h0000_5000);
    collect(8, 1'b0);
    check_stream(32'h0000_5000, 8);
  endtask

  task automatic test_pmp_fault();
    int cyc;
    // two good words before the fault
    branch_to(PMP_LO - 32'd8);
    cyc = 0;
    while (fetch_failed !== 1'b1 && cyc < TIMEOUT_CYC) begin
      @(posedge clk);
      cyc++;
    end
    if (fetch_failed !== 1'b1) begin
      $display("timeout waiting for fetch_failed_o to rise");
      timeouts++;
    end
    repeat (8) @(posedge clk);
    if (got_pc.size() != 2) begin
      $display("[ERROR] %0t transfer count expected 2 actual %0d", $time, got_pc.size());
      errors++;
    end
    check_stream(PMP_LO - 32'd8, 2);
    check_flag("fetch_failed_o", 1'b1, fetch_failed);
    // a branch clears the fault and fetching resumes
    branch_to(32'h0000_4000);
    check_flag("fetch_failed_o", 1'b0, fetch_failed);
    collect(4, 1'b0);
    check_stream(32'h0000_4000, 4);
    check_flag("fetch_failed_o", 1'b0, fetch_failed);
  endtask

  task automatic test_idle_after_stop();
    int cyc;
    // fetching is still running from the previous test
    check_flag("busy_o", 1'b1, busy);
    req <= 1'b0;
    cyc = 0;
    // pending response drains with decode ready
    while (busy !== 1'b0 && cyc < TIMEOUT_CYC) begin
      @(posedge clk);
      cyc++;
    end
    if (busy !== 1'b0) begin
      $display("timeout waiting for busy_o to fall");
      timeouts++;
    end
    check_quiet(10);
  endtask

`endif

/* verification/tb_instr_prefetch.sv */
// instruction prefetch testbench

`timescale 1ns/1ps
`default_nettype none

module tb_instr_prefetch;

  localparam int TIMEOUT_CYC = 1000;
  // reserved window, every fetch in here faults
  localparam instr_prefetch_pkg::addr_t PMP_LO = 32'h0000_8000;
  localparam instr_prefetch_pkg::addr_t PMP_HI = 32'h0000_80ff;

  logic                           clk, rst_n;
  logic                           req, branch, ready;
  instr_prefetch_pkg::addr_t      addr;
  instr_prefetch_pkg::imem_req_t  imem_req;
  instr_prefetch_pkg::imem_rsp_t  imem_rsp;
  instr_prefetch_pkg::fetch_out_t fetch;
  logic                           fetch_failed, busy;

  integer seed = 6;
  int     errors = 0;
  int     timeouts = 0;

  // words taken by decode, in order
  instr_prefetch_pkg::instr_t got_instr[$];
  instr_prefetch_pkg::addr_t  got_pc[$];

  // memory model state
  int                            gnt_wait, rv_wait, outstanding;
  logic                          gnt_armed, rv_busy;
  instr_prefetch_pkg::addr_t     rv_addr;
  instr_prefetch_pkg::imem_rsp_t rsp_nxt;

  // decode side hold tracking
  logic                           stalled;
  instr_prefetch_pkg::fetch_out_t held;

  tb_clk_gen #(.PERIOD_NS(4.0)) clk_gen_i (.clk_o(clk));

  instr_prefetch_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req),
    .branch_i       (branch),
    .addr_i         (addr),
    .ready_i        (ready),
    .imem_req_o     (imem_req),
    .imem_rsp_i     (imem_rsp),
    .fetch_o        (fetch),
    .fetch_failed_o (fetch_failed),
    .busy_o         (busy)
  );

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_instr(input string name, input instr_prefetch_pkg::instr_t exp,
                             input instr_prefetch_pkg::instr_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input instr_prefetch_pkg::addr_t exp,
                            input instr_prefetch_pkg::addr_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  function automatic logic in_pmp(input instr_prefetch_pkg::addr_t a);
    return (a >= PMP_LO) && (a <= PMP_HI);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // memory responder
  ////////////////////////////////////////////////////////////////////////////

  // looks at the cycle that just ended and drives the next one
  always @(posedge clk) begin
    rsp_nxt = '0;
    if (!rst_n) begin
      gnt_armed   = 1'b0;
      rv_busy     = 1'b0;
      outstanding = 0;
    end else begin
      if (imem_rsp.rvalid) outstanding--;
      // accepted request, data comes 1 to 3 cycles after the grant
      if (imem_rsp.gnt && !imem_rsp.err_pmp) begin
        outstanding++;
        rv_busy = 1'b1;
        rv_addr = imem_req.addr;
        rv_wait = $unsigned($random(seed)) % 3;
      end
      if (outstanding > 1) begin
        $display("more than one memory request outstanding at %0t", $time);
        errors++;
      end
      // grant 0 to 3 cycles after the request is first seen
      if (imem_rsp.gnt || !imem_req.req) begin
        gnt_armed = 1'b0;
      end else begin
        if (!gnt_armed) begin
          gnt_armed = 1'b1;
          gnt_wait  = $unsigned($random(seed)) % 4;
        end
        if (gnt_wait == 0) begin
          rsp_nxt.gnt     = 1'b1;
          rsp_nxt.err_pmp = in_pmp(imem_req.addr);
        end else begin
          gnt_wait--;
        end
      end
      if (rv_busy) begin
        if (rv_wait == 0) begin
          // memory word is the inverted address
          rsp_nxt.rvalid = 1'b1;
          rsp_nxt.rdata  = ~rv_addr;
          rv_busy        = 1'b0;
        end else begin
          rv_wait--;
        end
      end
    end
    imem_rsp <= rsp_nxt;
  end

  // decode side monitor, sampled mid cycle
  always @(negedge clk) begin
    if (!rst_n) begin
      stalled = 1'b0;
    end else begin
      // an offered word stays put until taken, a branch may kill it
      if (stalled && !branch) begin
        check_flag("fetch_o.valid", 1'b1, fetch.valid);
        check_instr("fetch_o.instr", held.instr, fetch.instr);
        check_addr("fetch_o.pc", held.pc, fetch.pc);
      end
      if (fetch.valid && ready) begin
        got_instr.push_back(fetch.instr);
        got_pc.push_back(fetch.pc);
      end
      stalled = fetch.valid && !ready;
      held    = fetch;
    end
  end

  `include "tb_instr_prefetch_tests.svh"

  initial begin
    rst_n    = 1'b0;
    req      = 1'b0;
    branch   = 1'b0;
    ready    = 1'b0;
    addr     = '0;
    imem_rsp = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    ready <= 1'b1;
    test_idle_after_reset();
    test_sequential();
    test_backpressure();
    test_branch_mid_stream();
    test_pmp_fault();
    test_idle_after_stop();
    $display("errors: %0d timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
